// ==== Bender.yml ====
package:
  name: float_mul_unit

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/float_fmt_pkg.sv
      - rtl/fpu_op_pkg.sv
      - rtl/float_op_decode.sv
      - rtl/float_mant_multiplier.sv
      - rtl/float_normalize_pack.sv
      - rtl/float_mul_unit.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/tb_float_mul_unit.sv

// ==== filelist.f ====
+incdir+rtl
rtl/float_fmt_pkg.sv
rtl/fpu_op_pkg.sv
rtl/float_op_decode.sv
rtl/float_mant_multiplier.sv
rtl/float_normalize_pack.sv
rtl/float_mul_unit.sv
tb/tb_float_mul_unit.sv

// ==== rtl/float_consts.svh ====
// format widths and multiplier iteration constants, included by RTL and testbench
`ifndef FLOAT_CONSTS_SVH
`define FLOAT_CONSTS_SVH

// ieee-754 single precision layout
`define FLOAT_WIDTH 32
`define FLOAT_EXP_WIDTH 8
`define FLOAT_MANT_WIDTH 23
`define FLOAT_EXP_BIAS 127

// radix-4 mantissa multiplier
`define MUL_BITS_PER_CYCLE 2

// 24 mantissa bits including the hidden one, two per step
`define MUL_STEPS ((`FLOAT_MANT_WIDTH + 1) / `MUL_BITS_PER_CYCLE)

`endif

// ==== rtl/float_fmt_pkg.sv ====
// number format types shared by the multiply unit stages and the testbench
`include "float_consts.svh"

package float_fmt_pkg;

    // packed ieee-754 word, {sign, exponent, stored mantissa}
    typedef logic [`FLOAT_WIDTH - 1:0] float_word_t;

    // mantissa with the hidden one in the top bit
    typedef logic [`FLOAT_MANT_WIDTH:0] mant_t;

    // full product of two hidden-one mantissas
    typedef logic [2 * `FLOAT_MANT_WIDTH + 1:0] product_t;

    // biased exponent sum before normalization
    // two extra bits cover the carry and the sign after subtracting the bias
    typedef logic signed [`FLOAT_EXP_WIDTH + 1:0] exp_acc_t;

endpackage

// ==== rtl/float_mant_multiplier.sv ====
// iterative radix-4 shift-add multiplier for the 24-bit hidden-one mantissas
`timescale 1ns/1ns
`include "float_consts.svh"

module float_mant_multiplier (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  float_fmt_pkg::mant_t    a_mant,
    input  float_fmt_pkg::mant_t    b_mant,
    output float_fmt_pkg::product_t product,
    output logic                    done
);
    localparam int MANT_W = `FLOAT_MANT_WIDTH + 1;
    localparam int CNT_W  = $clog2(`MUL_STEPS);

    logic                 running;
    logic [CNT_W - 1:0]   step;
    float_fmt_pkg::mant_t mplier;
    logic [MANT_W + 1:0]  partial;
    logic [MANT_W + 1:0]  upper_sum;

    // a_mant times the two low multiplier bits
    always_comb begin
        case (mplier[`MUL_BITS_PER_CYCLE - 1:0])
            2'd0:    partial = '0;
            2'd1:    partial = {2'b00, a_mant};
            2'd2:    partial = {1'b0, a_mant, 1'b0};
            default: partial = {2'b00, a_mant} + {1'b0, a_mant, 1'b0};
        endcase
    end

    // add into the upper half with the carry bits landing above it
    assign upper_sum = {2'b00, product[2 * MANT_W - 1 -: MANT_W]} + partial;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            running <= 1'b0;
            step    <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                step    <= '0;
            end else if (running) begin
                step <= step + 1'b1;
                if (step == CNT_W'(`MUL_STEPS - 1)) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // accumulator and shifting multiplier
    always_ff @(posedge clk) begin
        if (start) begin
            product <= '0;
            mplier  <= b_mant;
        end else if (running) begin
            product <= {upper_sum, product[MANT_W - 1:`MUL_BITS_PER_CYCLE]};
            mplier  <= mplier >> `MUL_BITS_PER_CYCLE;
        end
    end

    a_start_idle: assert property (@(posedge clk) disable iff (!rst) start |-> !running);

    // both mantissas carry the hidden one, so a finished product is at least 2^46
    a_prod_range: assert property (@(posedge clk) disable iff (!rst)
        done |-> (product[2 * MANT_W - 1] || product[2 * MANT_W - 2]));

endmodule

// ==== rtl/float_mul_unit.sv ====
// top of the float multiply unit, joins the decode, multiply and result stages
`timescale 1ns/1ns

module float_mul_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req,
    input  fpu_op_pkg::fpu_op_e        op,
    input  float_fmt_pkg::float_word_t a,
    input  float_fmt_pkg::float_word_t b,
    output logic                       ack,
    output float_fmt_pkg::float_word_t out
);
    logic                     start;
    logic                     zero_done;
    logic                     done;
    logic                     busy_clear;
    logic                     sign;
    float_fmt_pkg::mant_t     a_mant;
    float_fmt_pkg::mant_t     b_mant;
    float_fmt_pkg::exp_acc_t  exp_sum;
    float_fmt_pkg::product_t  product;

    float_op_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .op         (op),
        .a          (a),
        .b          (b),
        .busy_clear (busy_clear),
        .start      (start),
        .zero_done  (zero_done),
        .a_mant     (a_mant),
        .b_mant     (b_mant),
        .sign       (sign),
        .exp_sum    (exp_sum)
    );

    float_mant_multiplier u_mult (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .a_mant  (a_mant),
        .b_mant  (b_mant),
        .product (product),
        .done    (done)
    );

    float_normalize_pack u_pack (
        .clk        (clk),
        .rst        (rst),
        .done       (done),
        .zero_done  (zero_done),
        .product    (product),
        .sign       (sign),
        .exp_sum    (exp_sum),
        .out        (out),
        .ack        (ack),
        .busy_clear (busy_clear)
    );

endmodule

// ==== rtl/float_normalize_pack.sv ====
// result stage, normalizes the mantissa product and registers the packed word with ack
`timescale 1ns/1ns
`include "float_consts.svh"

module float_normalize_pack (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       done,
    input  logic                       zero_done,
    input  float_fmt_pkg::product_t    product,
    input  logic                       sign,
    input  float_fmt_pkg::exp_acc_t    exp_sum,
    output float_fmt_pkg::float_word_t out,
    output logic                       ack,
    output logic                       busy_clear
);
    localparam int TOP = 2 * `FLOAT_MANT_WIDTH + 1;

    logic [`FLOAT_MANT_WIDTH - 1:0] norm_mant;
    float_fmt_pkg::exp_acc_t        norm_exp;

    // product of two values in [1,2) lies in [1,4), one shift at most
    always_comb begin
        if (product[TOP]) begin
            norm_mant = product[TOP - 1 -: `FLOAT_MANT_WIDTH];
            norm_exp  = exp_sum + float_fmt_pkg::exp_acc_t'(1);
        end else begin
            norm_mant = product[TOP - 2 -: `FLOAT_MANT_WIDTH];
            norm_exp  = exp_sum;
        end
    end

    // frees the decode stage at the edge that registers the result
    assign busy_clear = done | zero_done;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out <= '0;
            ack <= 1'b0;
        end else begin
            ack <= done | zero_done;
            if (done) begin
                // low product bits are truncated
                out <= {sign, norm_exp[`FLOAT_EXP_WIDTH - 1:0], norm_mant};
            end else begin
                // zero result, and idle cycles, both give an all-zero word
                out <= '0;
            end
        end
    end

endmodule

// ==== rtl/float_op_decode.sv ====
// decode stage, accepts a request, unpacks the operands and starts the multiply or zero path
`timescale 1ns/1ns
`include "float_consts.svh"

module float_op_decode (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req,
    input  fpu_op_pkg::fpu_op_e       op,
    input  float_fmt_pkg::float_word_t a,
    input  float_fmt_pkg::float_word_t b,
    input  logic                      busy_clear,
    output logic                      start,
    output logic                      zero_done,
    output float_fmt_pkg::mant_t      a_mant,
    output float_fmt_pkg::mant_t      b_mant,
    output logic                      sign,
    output float_fmt_pkg::exp_acc_t   exp_sum
);
    logic                             busy;
    logic                             accept;
    float_fmt_pkg::float_word_t       opnd_b;
    logic [`FLOAT_EXP_WIDTH - 1:0]    a_exp;
    logic [`FLOAT_EXP_WIDTH - 1:0]    b_exp;

    assign accept = req && !busy;

    // square reuses a as the second operand
    assign opnd_b = (op == fpu_op_pkg::OP_SQUARE) ? a : b;
    assign a_exp  = a[`FLOAT_WIDTH - 2 -: `FLOAT_EXP_WIDTH];
    assign b_exp  = opnd_b[`FLOAT_WIDTH - 2 -: `FLOAT_EXP_WIDTH];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy      <= 1'b0;
            start     <= 1'b0;
            zero_done <= 1'b0;
        end else begin
            start     <= 1'b0;
            zero_done <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                // denormals count as zero, so any zero exponent field takes the shortcut
                if (a_exp == '0 || b_exp == '0) begin
                    zero_done <= 1'b1;
                end else begin
                    start <= 1'b1;
                end
            end else if (busy_clear) begin
                busy <= 1'b0;
            end
        end
    end

    // operand fields, held until the next accepted request
    always_ff @(posedge clk) begin
        if (accept) begin
            a_mant  <= {1'b1, a[`FLOAT_MANT_WIDTH - 1:0]};
            b_mant  <= {1'b1, opnd_b[`FLOAT_MANT_WIDTH - 1:0]};
            sign    <= a[`FLOAT_WIDTH - 1] ^ opnd_b[`FLOAT_WIDTH - 1]
                       ^ (op == fpu_op_pkg::OP_MUL_NEG);
            exp_sum <= float_fmt_pkg::exp_acc_t'(a_exp) + float_fmt_pkg::exp_acc_t'(b_exp)
                       - float_fmt_pkg::exp_acc_t'(`FLOAT_EXP_BIAS);
        end
    end

    // requester must wait for ack before the next req
    a_req_idle: assert property (@(posedge clk) disable iff (!rst) req |-> !busy);

    // a result only comes back for an accepted request
    a_clear_busy: assert property (@(posedge clk) disable iff (!rst) busy_clear |-> busy);

endmodule

// ==== rtl/fpu_op_pkg.sv ====
// operation set of the float multiply unit, used by the decode stage and the testbench
package fpu_op_pkg;

    // opcode driven by the requester with each req pulse
    typedef enum logic [1:0] {
        OP_MUL     = 2'd0,
        // product with the sign flipped
        OP_MUL_NEG = 2'd1,
        // a times a, b is ignored
        OP_SQUARE  = 2'd2
    } fpu_op_e;

endpackage

// ==== tb/tb_float_mul_unit.sv ====
// testbench for the float multiply unit, random requests checked against a reference model
`timescale 1ns/1ns
`include "float_consts.svh"

module tb_float_mul_unit;

    localparam int NUM_REQS   = 200;
    localparam int ACK_WAIT   = 20;
    localparam int MAX_CYCLES = NUM_REQS * (ACK_WAIT + 2) + 100;
    localparam int MW         = `FLOAT_MANT_WIDTH;
    localparam int EW         = `FLOAT_EXP_WIDTH;

    logic                       clk;
    logic                       rst;
    logic                       req;
    fpu_op_pkg::fpu_op_e        op;
    float_fmt_pkg::float_word_t a;
    float_fmt_pkg::float_word_t b;
    logic                       ack;
    float_fmt_pkg::float_word_t out;

    integer seed;
    int     cycles = 0;
    logic   pending;
    int     top_set_cnt;
    int     top_clear_cnt;

    float_mul_unit DUT (
        .clk (clk),
        .rst (rst),
        .req (req),
        .op  (op),
        .a   (a),
        .b   (b),
        .ack (ack),
        .out (out)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("error at %0t ns: %s got %h, expected %h", $time, what, got, expected);
            fail_run("value mismatch, stopping the run");
        end
    endtask

    // watchdog over the whole run
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            fail_run("timeout, the run did not finish within the cycle limit");
        end
    end

    // second operand after the opcode has been applied
    function automatic float_fmt_pkg::float_word_t second_operand(
        input fpu_op_pkg::fpu_op_e opc, input float_fmt_pkg::float_word_t x,
        input float_fmt_pkg::float_word_t y);
        return (opc == fpu_op_pkg::OP_SQUARE) ? x : y;
    endfunction

    function automatic logic [2 * MW + 1:0] mant_product(input float_fmt_pkg::float_word_t x,
                                                        input float_fmt_pkg::float_word_t y);
        logic [2 * MW + 1:0] mx;
        logic [2 * MW + 1:0] my;
        mx = {1'b1, x[MW - 1:0]};
        my = {1'b1, y[MW - 1:0]};
        return mx * my;
    endfunction

    // reference model, truncating multiply with the zero shortcut
    function automatic float_fmt_pkg::float_word_t expected_result(
        input fpu_op_pkg::fpu_op_e opc, input float_fmt_pkg::float_word_t x,
        input float_fmt_pkg::float_word_t y_in);
        float_fmt_pkg::float_word_t y;
        logic [2 * MW + 1:0]        prod;
        logic                       s;
        int                         e;
        logic [MW - 1:0]            m;
        y = second_operand(opc, x, y_in);
        if (x[MW +: EW] == 0 || y[MW +: EW] == 0) begin
            return '0;
        end
        s = x[31] ^ y[31] ^ (opc == fpu_op_pkg::OP_MUL_NEG);
        prod = mant_product(x, y);
        e = int'(x[MW +: EW]) + int'(y[MW +: EW]) - `FLOAT_EXP_BIAS;
        if (prod[2 * MW + 1]) begin
            m = prod[2 * MW -: MW];
            e = e + 1;
        end else begin
            m = prod[2 * MW - 1 -: MW];
        end
        return {s, e[EW - 1:0], m};
    endfunction

    // exponent 64..190 keeps the result in range
    // about one operand in eight gets a zero exponent
    function automatic float_fmt_pkg::float_word_t random_operand();
        logic [31:0]     r;
        logic [EW - 1:0] e;
        logic [MW - 1:0] m;
        r = $random(seed);
        m = $random(seed);
        if ($unsigned($random(seed)) % 8 == 0) begin
            e = '0;
        end else begin
            e = EW'(64 + $unsigned($random(seed)) % 127);
        end
        return {r[31], e, m};
    endfunction

    task automatic observe_cycle(output logic seen);
        seen = 1'b0;
        if (ack === 1'b1) begin
            if (!pending) begin
                fail_run("ack arrived without a pending request");
            end
            pending = 1'b0;
            seen = 1'b1;
        end else begin
            check_value(ack, 32'd0, "ack");
            check_value(out, 32'd0, "out while ack is low");
        end
    endtask

    task automatic idle_cycle();
        logic seen;
        @(posedge clk);
        @(negedge clk);
        observe_cycle(seen);
    endtask

    task automatic run_request(input fpu_op_pkg::fpu_op_e opc,
                               input float_fmt_pkg::float_word_t x,
                               input float_fmt_pkg::float_word_t y);
        float_fmt_pkg::float_word_t want;
        logic                       seen;
        int                         waited;
        want = expected_result(opc, x, y);
        @(posedge clk);
        req <= 1'b1;
        op  <= opc;
        a   <= x;
        b   <= y;
        @(negedge clk);
        observe_cycle(seen);
        pending = 1'b1;
        waited = 0;
        seen = 1'b0;
        while (!seen && waited < ACK_WAIT) begin
            @(posedge clk);
            if (waited == 0) begin
                // operands are latched, new values must not matter
                req <= 1'b0;
                a   <= $random(seed);
                b   <= $random(seed);
            end
            @(negedge clk);
            observe_cycle(seen);
            waited++;
        end
        if (!seen) begin
            fail_run($sformatf("no ack within %0d cycles of a request", ACK_WAIT));
        end
        check_value(out, want, "result");
    endtask

    initial begin
        int                         i;
        fpu_op_pkg::fpu_op_e        opc;
        float_fmt_pkg::float_word_t x;
        float_fmt_pkg::float_word_t y;
        float_fmt_pkg::float_word_t y_eff;
        logic                       seen;
        seed          = 46233;
        req           = 1'b0;
        op            = fpu_op_pkg::OP_MUL;
        a             = '0;
        b             = '0;
        rst           = 1'b0;
        pending       = 1'b0;
        top_set_cnt   = 0;
        top_clear_cnt = 0;
        repeat (2) idle_cycle();
        @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        observe_cycle(seen);
        // quiet outputs before the first request
        repeat (4) idle_cycle();
        for (i = 0; i < NUM_REQS; i++) begin
            opc   = fpu_op_pkg::fpu_op_e'($unsigned($random(seed)) % 3);
            x     = random_operand();
            y     = random_operand();
            y_eff = second_operand(opc, x, y);
            if (x[MW +: EW] != 0 && y_eff[MW +: EW] != 0) begin
                if (mant_product(x, y_eff) >> (2 * MW + 1)) begin
                    top_set_cnt++;
                end else begin
                    top_clear_cnt++;
                end
            end
            run_request(opc, x, y);
        end
        repeat (4) idle_cycle();
        if (top_set_cnt == 0 || top_clear_cnt == 0) begin
            fail_run("random operands did not reach both normalization cases");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule
